/* filelist.f */
src/fu_pkg.sv
src/cond_eval.sv
src/alu_unit.sv
src/ls_unit.sv
src/func_units.sv
tests/func_units_checker.sv
tests/func_units_tb.sv

/* Makefile */
# Verilator flow for the execution stage
TOP       ?= func_units_tb
DUT_TOP   ?= func_units
FILELIST  ?= filelist.f
LOG       ?= sim.log
VERILATOR ?= verilator
# Runtime seed of the Verilator model
SEED      ?= 1
OBJ_DIR   ?= obj_dir

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter src/%,$(SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
	  -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Result decided from the log only
run: $(SIM_BIN)
	-./$(SIM_BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)
	@! grep -q "RESULT: FAIL" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(DUT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/func_units_tb.sv */
module func_units_tb;

  // One table row, unit select first
  typedef struct packed {
    logic is_ls;
    fu_pkg::fu_op_t op;
    fu_pkg::gpr_t a;
    fu_pkg::gpr_t b;
    logic set_nzcv;
    fu_pkg::nzcv_t nzcv;
    fu_pkg::cond_t cond;
    fu_pkg::gpr_t exp_value;
    fu_pkg::nzcv_t exp_nzcv;
    logic exp_cond;
  } stim_t;

  logic in_clk = 1'b0;
  logic reset;
  fu_pkg::rs_issue_t alu_issue;
  fu_pkg::rs_alu_ext_t alu_ext;
  fu_pkg::rs_issue_t ls_issue;
  fu_pkg::fu_result_t rob_result;
  fu_pkg::fu_alu_ext_t rob_alu_ext;

  stim_t stim_q [$];
  // ROB index sent with each row
  fu_pkg::rob_index_t sent_idx [$];
  integer seed;
  int fail_count;

  always #4 in_clk = ~in_clk;

  func_units func_units_inst (
    .in_clk(in_clk),
    .reset(reset),
    .alu_issue(alu_issue),
    .alu_ext(alu_ext),
    .ls_issue(ls_issue),
    .rob_result(rob_result),
    .rob_alu_ext(rob_alu_ext)
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_count++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic add_alu(input fu_pkg::fu_op_t op, input fu_pkg::gpr_t a,
                         input fu_pkg::gpr_t b, input logic set_nzcv,
                         input fu_pkg::nzcv_t nzcv, input fu_pkg::cond_t cond,
                         input fu_pkg::gpr_t exp_value, input fu_pkg::nzcv_t exp_nzcv,
                         input logic exp_cond);
    stim_q.push_back('{1'b0, op, a, b, set_nzcv, nzcv, cond, exp_value, exp_nzcv, exp_cond});
  endtask

  // val_a is the address, val_b the store data
  task automatic add_mem(input fu_pkg::fu_op_t op, input fu_pkg::gpr_t addr,
                         input fu_pkg::gpr_t data, input fu_pkg::gpr_t exp_value);
    stim_q.push_back('{1'b1, op, addr, data, 1'b0, 4'h0, fu_pkg::COND_AL, exp_value, 4'h0, 1'b0});
  endtask

  task automatic build_table();
    // Plain ALU ops, AL so condition is always 1
    add_alu(fu_pkg::FU_OP_PLUS, 64'h5, 64'h7, 1'b1, 4'h0, fu_pkg::COND_AL, 64'hc, 4'h0, 1'b1);
    add_alu(fu_pkg::FU_OP_PLUS, 64'hffff_ffff_ffff_ffff, 64'h1, 1'b0, 4'h0, fu_pkg::COND_AL,
            64'h0, 4'h6, 1'b1);
    // Max positive plus one overflows
    add_alu(fu_pkg::FU_OP_PLUS, 64'h7fff_ffff_ffff_ffff, 64'h1, 1'b1, 4'h0, fu_pkg::COND_AL,
            64'h8000_0000_0000_0000, 4'h9, 1'b1);
    add_alu(fu_pkg::FU_OP_MINUS, 64'ha, 64'h3, 1'b0, 4'h0, fu_pkg::COND_AL, 64'h7, 4'h2, 1'b1);
    add_alu(fu_pkg::FU_OP_MINUS, 64'h3, 64'ha, 1'b1, 4'h0, fu_pkg::COND_AL,
            64'hffff_ffff_ffff_fff9, 4'h8, 1'b1);
    add_alu(fu_pkg::FU_OP_MINUS, 64'h5, 64'h5, 1'b0, 4'h0, fu_pkg::COND_AL, 64'h0, 4'h6, 1'b1);
    add_alu(fu_pkg::FU_OP_AND, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00, 1'b1, 4'hf,
            fu_pkg::COND_AL, 64'hf000_f000_f000_f000, 4'h8, 1'b1);
    add_alu(fu_pkg::FU_OP_OR, 64'hf0, 64'h0f, 1'b0, 4'h0, fu_pkg::COND_AL, 64'hff, 4'h0, 1'b1);
    add_alu(fu_pkg::FU_OP_ORN, 64'h0, 64'hffff_ffff_ffff_ffff, 1'b1, 4'h0, fu_pkg::COND_AL,
            64'h0, 4'h4, 1'b1);
    add_alu(fu_pkg::FU_OP_EOR, 64'haaaa_aaaa_aaaa_aaaa, 64'hffff_ffff_ffff_ffff, 1'b0, 4'hf,
            fu_pkg::COND_AL, 64'h5555_5555_5555_5555, 4'h0, 1'b1);
    add_alu(fu_pkg::FU_OP_PASS_A, 64'h8000_0000_0000_0001, 64'h123, 1'b1, 4'h0,
            fu_pkg::COND_AL, 64'h8000_0000_0000_0001, 4'h8, 1'b1);
    // Memory interleaved with conditional selects
    add_mem(fu_pkg::FU_OP_STUR, 64'h10, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef);
    add_mem(fu_pkg::FU_OP_STUR, 64'h40, 64'hfedc_ba98_7654_3210, 64'hfedc_ba98_7654_3210);
    add_alu(fu_pkg::FU_OP_CSEL, 64'h11, 64'h22, 1'b0, 4'h4, fu_pkg::COND_EQ,
            64'h11, 4'h0, 1'b1);
    add_mem(fu_pkg::FU_OP_LDUR, 64'h10, 64'h0, 64'h0123_4567_89ab_cdef);
    add_alu(fu_pkg::FU_OP_CSEL, 64'h11, 64'h22, 1'b1, 4'h0, fu_pkg::COND_EQ,
            64'h22, 4'h0, 1'b0);
    add_mem(fu_pkg::FU_OP_LDUR, 64'h40, 64'h0, 64'hfedc_ba98_7654_3210);
    add_alu(fu_pkg::FU_OP_CSINC, 64'h11, 64'h22, 1'b0, 4'h0, fu_pkg::COND_NE,
            64'h11, 4'h0, 1'b1);
    // Upper half of the first store overwritten
    add_mem(fu_pkg::FU_OP_STUR, 64'h14, 64'h1122_3344_5566_7788, 64'h1122_3344_5566_7788);
    add_mem(fu_pkg::FU_OP_LDUR, 64'h10, 64'h0, 64'h5566_7788_89ab_cdef);
    add_alu(fu_pkg::FU_OP_CSINC, 64'h11, 64'h22, 1'b1, 4'h4, fu_pkg::COND_NE,
            64'h23, 4'h0, 1'b0);
    add_alu(fu_pkg::FU_OP_CSINV, 64'h11, 64'h22, 1'b0, 4'h9, fu_pkg::COND_GE,
            64'h11, 4'h0, 1'b1);
    add_alu(fu_pkg::FU_OP_CSINV, 64'h11, 64'h22, 1'b1, 4'h8, fu_pkg::COND_GE,
            64'hffff_ffff_ffff_ffdd, 4'h8, 1'b0);
    add_alu(fu_pkg::FU_OP_CSNEG, 64'h11, 64'h22, 1'b0, 4'h8, fu_pkg::COND_LT,
            64'h11, 4'h0, 1'b1);
    add_alu(fu_pkg::FU_OP_CSNEG, 64'h11, 64'h22, 1'b1, 4'h0, fu_pkg::COND_LT,
            64'hffff_ffff_ffff_ffde, 4'h8, 1'b0);
    add_alu(fu_pkg::FU_OP_CSEL, 64'h11, 64'h22, 1'b0, 4'h2, fu_pkg::COND_HI,
            64'h11, 4'h0, 1'b1);
    add_alu(fu_pkg::FU_OP_CSEL, 64'h11, 64'h22, 1'b1, 4'h6, fu_pkg::COND_HI,
            64'h22, 4'h0, 1'b0);
    // Address bits above 10 ignored, bytes wrap to 0
    add_mem(fu_pkg::FU_OP_STUR, 64'h13fc, 64'ha1a2_a3a4_a5a6_a7a8, 64'ha1a2_a3a4_a5a6_a7a8);
    add_mem(fu_pkg::FU_OP_LDUR, 64'h3fc, 64'h0, 64'ha1a2_a3a4_a5a6_a7a8);
    add_mem(fu_pkg::FU_OP_LDUR, 64'h14, 64'h0, 64'h1122_3344_5566_7788);
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    @(negedge in_clk);
    while (rob_result.done !== 1'b1) begin
      cycles++;
      if (cycles >= 20) begin
        fail_count++;
        $display("Timed out after 20 cycles waiting for rob_result.done");
        $display("RESULT: FAIL");
        $fatal(1, "no result from the DUT");
      end
      @(negedge in_clk);
    end
  endtask

  // One row per cycle, back to back
  task automatic issue_table();
    logic [31:0] rnd;
    fu_pkg::rob_index_t idx;
    stim_t s;
    for (int i = 0; i < stim_q.size(); i++) begin
      @(posedge in_clk);
      s = stim_q[i];
      rnd = $random(seed);
      idx = rnd[fu_pkg::ROB_IDX_W-1:0];
      sent_idx.push_back(idx);
      if (s.is_ls) begin
        ls_issue <= '{1'b1, s.op, idx, s.a, s.b};
        alu_issue.start <= 1'b0;
      end else begin
        alu_issue <= '{1'b1, s.op, idx, s.a, s.b};
        alu_ext <= '{s.set_nzcv, s.nzcv, s.cond};
        ls_issue.start <= 1'b0;
      end
    end
    @(posedge in_clk);
    alu_issue.start <= 1'b0;
    ls_issue.start <= 1'b0;
  endtask

  task automatic check_results();
    stim_t s;
    for (int i = 0; i < stim_q.size(); i++) begin
      s = stim_q[i];
      wait_done();
      check_value("rob_result.value", rob_result.value, s.exp_value);
      check_value("rob_result.dst_rob_index", 64'(rob_result.dst_rob_index), 64'(sent_idx[i]));
      // Flags only mean something for ALU rows
      if (!s.is_ls) begin
        check_value("rob_alu_ext.nzcv", 64'(rob_alu_ext.nzcv), 64'(s.exp_nzcv));
        check_value("rob_alu_ext.condition", 64'(rob_alu_ext.condition), 64'(s.exp_cond));
        check_value("rob_alu_ext.set_nzcv", 64'(rob_alu_ext.set_nzcv), 64'(s.set_nzcv));
      end
    end
  endtask

  initial begin
    seed = 32'hadbd41bf;
    fail_count = 0;
    reset <= 1'b1;
    alu_issue <= '0;
    alu_ext <= '0;
    ls_issue <= '0;
    build_table();
    // 16 reset edges, then idle cycles with no start
    for (int c = 0; c < 20; c++) begin
      @(posedge in_clk);
      // Starts while reset is high, one unit at a time
      alu_issue.start <= (c < 12) && (c % 2 == 0);
      ls_issue.start <= (c < 12) && (c % 2 == 1);
      if (c == 15) begin
        reset <= 1'b0;
      end
      @(negedge in_clk);
      check_value("rob_result.done", 64'(rob_result.done), 64'h0);
    end
    fork
      issue_table();
      check_results();
    join
    if (fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tests/func_units_checker.sv */
module func_units_checker (
  input logic in_clk,
  input logic reset,
  input fu_pkg::rs_issue_t alu_issue,
  input fu_pkg::rs_issue_t ls_issue,
  input fu_pkg::fu_result_t alu_result,
  input fu_pkg::fu_result_t ls_result,
  input fu_pkg::fu_result_t rob_result
);

  logic any_start;

  // Either issue port starting this cycle
  assign any_start = alu_issue.start | ls_issue.start;

  // Single result port, so the units never finish together
  done_exclusive: assert property (@(posedge in_clk) disable iff (reset)
    !(alu_result.done && ls_result.done))
    else $error("ALU and load/store done strobes high in the same cycle");

  // Done cleared by every reset edge
  done_low_after_reset: assert property (@(posedge in_clk)
    reset |=> !rob_result.done)
    else $error("rob_result.done high in the cycle after a reset edge");

  // Latency of one
  done_after_start: assert property (@(posedge in_clk) disable iff (reset)
    any_start |=> rob_result.done)
    else $error("rob_result.done missing one cycle after a start");

  // No result without a start the cycle before
  no_done_without_start: assert property (@(posedge in_clk) disable iff (reset)
    !any_start |=> !rob_result.done)
    else $error("rob_result.done high without a start one cycle earlier");

endmodule

bind func_units func_units_checker checker_inst (
  .in_clk(in_clk),
  .reset(reset),
  .alu_issue(alu_issue),
  .ls_issue(ls_issue),
  .alu_result(alu_result),
  .ls_result(ls_result),
  .rob_result(rob_result)
);

/* src/func_units.sv */
module func_units (
  input logic in_clk,
  input logic reset,
  input fu_pkg::rs_issue_t alu_issue,
  input fu_pkg::rs_alu_ext_t alu_ext,
  input fu_pkg::rs_issue_t ls_issue,
  output fu_pkg::fu_result_t rob_result,
  output fu_pkg::fu_alu_ext_t rob_alu_ext
);

  // Per-unit results
  fu_pkg::fu_result_t alu_result;
  fu_pkg::fu_alu_ext_t alu_flags;
  fu_pkg::fu_result_t ls_result;

  alu_unit alu_inst (
    .in_clk(in_clk),
    .reset(reset),
    .issue(alu_issue),
    .ext(alu_ext),
    .result(alu_result),
    .flags(alu_flags)
  );

  ls_unit ls_inst (
    .in_clk(in_clk),
    .reset(reset),
    .issue(ls_issue),
    .result(ls_result)
  );

  // Single ROB write port
  // Only one unit is done per cycle, ALU first if both
  always_comb begin
    rob_result.done = alu_result.done | ls_result.done;
    if (alu_result.done) begin
      rob_result.dst_rob_index = alu_result.dst_rob_index;
      rob_result.value         = alu_result.value;
    end else begin
      rob_result.dst_rob_index = ls_result.dst_rob_index;
      rob_result.value         = ls_result.value;
    end
  end

  // Flags always come from the ALU
  assign rob_alu_ext = alu_flags;

endmodule

/* src/ls_unit.sv */
module ls_unit (
  input logic in_clk,
  input logic reset,
  input fu_pkg::rs_issue_t issue,
  output fu_pkg::fu_result_t result
);

  // Byte array, little endian words
  logic [7:0] mem [fu_pkg::DMEM_BYTES];

  // Address taken from the low bits of val_a
  fu_pkg::dmem_addr_t addr;
  logic is_store;

  // Registered access
  logic done_q;
  fu_pkg::dmem_addr_t addr_q;
  fu_pkg::rob_index_t idx_q;
  logic store_q;
  fu_pkg::gpr_t wdata_q;

  fu_pkg::gpr_t rdata;

  assign addr     = issue.val_a[fu_pkg::DMEM_AW-1:0];
  assign is_store = (issue.fu_op == fu_pkg::FU_OP_STUR);

  // Store lands on the start edge
  // Byte offsets wrap with the address width
  always_ff @(posedge in_clk) begin
    if (issue.start && is_store) begin
      for (int i = 0; i < 8; i++) begin
        mem[addr + fu_pkg::dmem_addr_t'(i)] <= issue.val_b[8*i +: 8];
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (reset) begin
      done_q <= 1'b0;
    end else begin
      done_q <= issue.start;
    end
  end

  // Access fields kept for the result cycle
  always_ff @(posedge in_clk) begin
    if (issue.start) begin
      addr_q  <= addr;
      idx_q   <= issue.dst_rob_index;
      store_q <= is_store;
      wdata_q <= issue.val_b;
    end
  end

  // Read 8 bytes, lowest address in the low byte
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      rdata[8*i +: 8] = mem[addr_q + fu_pkg::dmem_addr_t'(i)];
    end
  end

  always_comb begin
    result.done          = done_q;
    result.dst_rob_index = idx_q;
    // A store reports the data it wrote
    result.value         = store_q ? wdata_q : rdata;
  end

endmodule

/* src/alu_unit.sv */
module alu_unit (
  input logic in_clk,
  input logic reset,
  input fu_pkg::rs_issue_t issue,
  input fu_pkg::rs_alu_ext_t ext,
  output fu_pkg::fu_result_t result,
  output fu_pkg::fu_alu_ext_t flags
);

  // Captured issue
  logic done_q;
  fu_pkg::fu_op_t op_q;
  fu_pkg::rob_index_t idx_q;
  fu_pkg::gpr_t a_q;
  fu_pkg::gpr_t b_q;
  fu_pkg::rs_alu_ext_t ext_q;

  // Condition outcome for the selects
  logic holds;

  // Wide add and subtract, top bit is the carry
  logic [fu_pkg::GPR_W:0] sum;
  logic [fu_pkg::GPR_W:0] diff;

  fu_pkg::gpr_t value;
  logic carry;
  logic ovf;

  // Done follows start by one edge
  always_ff @(posedge in_clk) begin
    if (reset) begin
      done_q <= 1'b0;
    end else begin
      done_q <= issue.start;
    end
  end

  // Operands held until the next start
  always_ff @(posedge in_clk) begin
    if (issue.start) begin
      op_q  <= issue.fu_op;
      idx_q <= issue.dst_rob_index;
      a_q   <= issue.val_a;
      b_q   <= issue.val_b;
      ext_q <= ext;
    end
  end

  cond_eval cond_inst (
    .cond(ext_q.cond_codes),
    .nzcv(ext_q.nzcv),
    .holds(holds)
  );

  assign sum  = {1'b0, a_q} + {1'b0, b_q};
  // Borrow shows up in the top bit
  assign diff = {1'b0, a_q} - {1'b0, b_q};

  always_comb begin
    carry = 1'b0;
    ovf   = 1'b0;
    case (op_q)
      fu_pkg::FU_OP_PLUS: begin
        value = sum[fu_pkg::GPR_W-1:0];
        carry = sum[fu_pkg::GPR_W];
        // Same-sign operands, result sign flipped
        ovf   = (a_q[fu_pkg::GPR_W-1] == b_q[fu_pkg::GPR_W-1]) &
                (value[fu_pkg::GPR_W-1] != a_q[fu_pkg::GPR_W-1]);
      end
      fu_pkg::FU_OP_MINUS: begin
        value = diff[fu_pkg::GPR_W-1:0];
        // No borrow means a >= b unsigned
        carry = ~diff[fu_pkg::GPR_W];
        ovf   = (a_q[fu_pkg::GPR_W-1] != b_q[fu_pkg::GPR_W-1]) &
                (value[fu_pkg::GPR_W-1] != a_q[fu_pkg::GPR_W-1]);
      end
      fu_pkg::FU_OP_AND:    value = a_q & b_q;
      fu_pkg::FU_OP_OR:     value = a_q | b_q;
      fu_pkg::FU_OP_ORN:    value = a_q | ~b_q;
      fu_pkg::FU_OP_EOR:    value = a_q ^ b_q;
      fu_pkg::FU_OP_PASS_A: value = a_q;
      // Selects, val_a when the condition holds
      fu_pkg::FU_OP_CSEL:   value = holds ? a_q : b_q;
      fu_pkg::FU_OP_CSINC:  value = holds ? a_q : b_q + fu_pkg::gpr_t'(1);
      fu_pkg::FU_OP_CSINV:  value = holds ? a_q : ~b_q;
      fu_pkg::FU_OP_CSNEG:  value = holds ? a_q : -b_q;
      // Memory ops never reach the ALU
      default:              value = '0;
    endcase
  end

  always_comb begin
    result.done          = done_q;
    result.dst_rob_index = idx_q;
    result.value         = value;

    flags.set_nzcv = ext_q.set_nzcv;
    flags.nzcv[fu_pkg::NZCV_N] = value[fu_pkg::GPR_W-1];
    flags.nzcv[fu_pkg::NZCV_Z] = (value == '0);
    flags.nzcv[fu_pkg::NZCV_C] = carry;
    flags.nzcv[fu_pkg::NZCV_V] = ovf;
    flags.condition = holds;
  end

endmodule

/* src/cond_eval.sv */
module cond_eval (
  input fu_pkg::cond_t cond,
  input fu_pkg::nzcv_t nzcv,
  output logic holds
);

  logic n;
  logic z;
  logic c;
  logic v;

  // Unpack the flags once
  assign n = nzcv[fu_pkg::NZCV_N];
  assign z = nzcv[fu_pkg::NZCV_Z];
  assign c = nzcv[fu_pkg::NZCV_C];
  assign v = nzcv[fu_pkg::NZCV_V];

  always_comb begin
    case (cond)
      fu_pkg::COND_EQ: holds = z;
      fu_pkg::COND_NE: holds = ~z;
      fu_pkg::COND_CS: holds = c;
      fu_pkg::COND_CC: holds = ~c;
      fu_pkg::COND_MI: holds = n;
      fu_pkg::COND_PL: holds = ~n;
      fu_pkg::COND_VS: holds = v;
      fu_pkg::COND_VC: holds = ~v;
      // Unsigned higher, and lower or same
      fu_pkg::COND_HI: holds = c & ~z;
      fu_pkg::COND_LS: holds = ~(c & ~z);
      // Signed compares
      fu_pkg::COND_GE: holds = (n == v);
      fu_pkg::COND_LT: holds = (n != v);
      fu_pkg::COND_GT: holds = (n == v) & ~z;
      fu_pkg::COND_LE: holds = ~((n == v) & ~z);
      // NV behaves like AL on this core
      fu_pkg::COND_AL: holds = 1'b1;
      fu_pkg::COND_NV: holds = 1'b1;
      default: holds = 1'b1;
    endcase
  end

endmodule

/* src/fu_pkg.sv */
package fu_pkg;

  // Data path and ROB sizing
  localparam int GPR_W = 64;
  localparam int ROB_IDX_W = 5;

  // Data memory, byte addressed
  localparam int DMEM_BYTES = 1024;
  localparam int DMEM_AW = 10;

  typedef logic [GPR_W-1:0] gpr_t;
  typedef logic [ROB_IDX_W-1:0] rob_index_t;
  typedef logic [DMEM_AW-1:0] dmem_addr_t;

  // Flags as N Z C V, N in the top bit
  typedef logic [3:0] nzcv_t;

  localparam int NZCV_N = 3;
  localparam int NZCV_Z = 2;
  localparam int NZCV_C = 1;
  localparam int NZCV_V = 0;

  // ARM condition field
  typedef logic [3:0] cond_t;

  localparam cond_t COND_EQ = 4'd0;
  localparam cond_t COND_NE = 4'd1;
  localparam cond_t COND_CS = 4'd2;
  localparam cond_t COND_CC = 4'd3;
  localparam cond_t COND_MI = 4'd4;
  localparam cond_t COND_PL = 4'd5;
  localparam cond_t COND_VS = 4'd6;
  localparam cond_t COND_VC = 4'd7;
  localparam cond_t COND_HI = 4'd8;
  localparam cond_t COND_LS = 4'd9;
  localparam cond_t COND_GE = 4'd10;
  localparam cond_t COND_LT = 4'd11;
  localparam cond_t COND_GT = 4'd12;
  localparam cond_t COND_LE = 4'd13;
  localparam cond_t COND_AL = 4'd14;
  localparam cond_t COND_NV = 4'd15;

  // Operations handled by the execution stage
  typedef enum logic [3:0] {
    FU_OP_PLUS   = 4'd0,
    FU_OP_MINUS  = 4'd1,
    FU_OP_AND    = 4'd2,
    FU_OP_OR     = 4'd3,
    FU_OP_ORN    = 4'd4,
    FU_OP_EOR    = 4'd5,
    FU_OP_PASS_A = 4'd6,
    FU_OP_CSEL   = 4'd7,
    FU_OP_CSINC  = 4'd8,
    FU_OP_CSINV  = 4'd9,
    FU_OP_CSNEG  = 4'd10,
    FU_OP_LDUR   = 4'd11,
    FU_OP_STUR   = 4'd12
  } fu_op_t;

  // One issue from the reservation station, valid with start
  typedef struct packed {
    logic       start;
    fu_op_t     fu_op;
    rob_index_t dst_rob_index;
    gpr_t       val_a;
    gpr_t       val_b;
  } rs_issue_t;

  // Extra ALU issue fields
  typedef struct packed {
    logic  set_nzcv;
    nzcv_t nzcv;
    cond_t cond_codes;
  } rs_alu_ext_t;

  // Result towards the ROB, valid with done
  typedef struct packed {
    logic       done;
    rob_index_t dst_rob_index;
    gpr_t       value;
  } fu_result_t;

  // Flag side of an ALU result
  typedef struct packed {
    logic  set_nzcv;
    nzcv_t nzcv;
    logic  condition;
  } fu_alu_ext_t;

endpackage
